/* ahb_pkg.sv */
package ahb_pkg;

    // transfer type
    typedef enum logic [1:0] {
        htrans_idle   = 2'b00,
        htrans_busy   = 2'b01,
        htrans_nonseq = 2'b10,
        htrans_seq    = 2'b11
    } htrans_e;

    // transfer size, nothing wider than a word on this bus
    typedef enum logic [2:0] {
        hsize_byte     = 3'b000,
        hsize_halfword = 3'b001,
        hsize_word     = 3'b010
    } hsize_e;

    typedef enum logic {
        hresp_okay  = 1'b0,
        hresp_error = 1'b1
    } hresp_e;

    // address phase, driven by the matrix to every slave
    typedef struct packed {
        logic [31:0] haddr;
        htrans_e     htrans;
        logic        hwrite;
        hsize_e      hsize;
        logic [2:0]  hburst;     // carried only, bursts run as singles
        logic [3:0]  hprot;      // ignored
        logic        hmastlock;  // ignored, single master
    } ahb_addr_t;

    // what each slave hands back in the data phase
    typedef struct packed {
        logic [31:0] hrdata;
        logic        hreadyout;
        hresp_e      hresp;
    } ahb_resp_t;

endpackage

/* soc_map_pkg.sv */
package soc_map_pkg;

    // slave index, also the bit position in the one-hot select
    typedef enum int unsigned {
        boot_ram = 0,
        main_ram = 1,
        gpio     = 2,
        timer    = 3,
        none     = 4
    } region_e;

    localparam int unsigned NUM_REGIONS = int'(none) + 1;

    // match values on physical bits 28..22
    localparam logic [6:0] BOOT_RAM_MATCH = 7'h7F;  // 0x1fc00000
    localparam logic       MAIN_RAM_MATCH = 1'b0;   // bit 28 only
    localparam logic [6:0] GPIO_MATCH     = 7'h7E;  // 0x1f800000
    localparam logic [6:0] TIMER_MATCH    = 7'h7D;  // 0x1f400000

    // gpio byte offsets
    localparam logic [5:0] GPIO_OFS_RED_LEDS   = 6'h00;
    localparam logic [5:0] GPIO_OFS_GREEN_LEDS = 6'h04;
    localparam logic [5:0] GPIO_OFS_SWITCHES   = 6'h08;
    localparam logic [5:0] GPIO_OFS_BUTTONS    = 6'h0C;

    // timer byte offsets
    localparam logic [5:0] TIMER_OFS_COUNT   = 6'h00;
    localparam logic [5:0] TIMER_OFS_COMPARE = 6'h04;
    localparam logic [5:0] TIMER_OFS_STATUS  = 6'h08;

    typedef struct packed {
        logic [9:0]  upper;   // [6:0] are physical bits 28..22
        logic [19:0] word;
        logic [1:0]  lane;
    } mem_view_t;

    typedef struct packed {
        logic [9:0]  region;
        logic [15:0] unused;
        logic [3:0]  regno;
        logic [1:0]  lane;
    } periph_view_t;

    // one address word, read as memory or as peripheral register
    typedef union packed {
        mem_view_t    mem;
        periph_view_t periph;
    } haddr_view_u;

endpackage

/* ahb_decoder.sv */
module ahb_decoder (
    input  ahb_pkg::ahb_addr_t                    addr,
    output logic [soc_map_pkg::NUM_REGIONS-1:0]   sel
);

    soc_map_pkg::haddr_view_u av;
    logic hit_boot;
    logic hit_main;
    logic hit_gpio;
    logic hit_timer;

    assign av = addr.haddr;

    assign hit_boot  = av.mem.upper[6:0] == soc_map_pkg::BOOT_RAM_MATCH;
    assign hit_gpio  = av.mem.upper[6:0] == soc_map_pkg::GPIO_MATCH;
    assign hit_timer = av.mem.upper[6:0] == soc_map_pkg::TIMER_MATCH;
    // boot ram wins over main ram
    assign hit_main  = !hit_boot && (av.mem.upper[6] == soc_map_pkg::MAIN_RAM_MATCH);

    always_comb begin
        sel = '0;
        sel[soc_map_pkg::boot_ram] = hit_boot;
        sel[soc_map_pkg::main_ram] = hit_main;
        sel[soc_map_pkg::gpio]     = hit_gpio;
        sel[soc_map_pkg::timer]    = hit_timer;
        // anything left over goes to the default slave
        sel[soc_map_pkg::none]     = !(hit_boot || hit_main || hit_gpio || hit_timer);
    end

endmodule

/* ahb_mem_slave.sv */
module ahb_mem_slave #(
    parameter int ADDR_WIDTH = 16
) (
    input  logic               HCLK,
    input  logic               rst_n,
    input  ahb_pkg::ahb_addr_t addr,
    input  logic               sel,
    input  logic               hready,
    input  logic [31:0]        hwdata,
    output ahb_pkg::ahb_resp_t resp
);

    localparam int WORDS = 2 ** (ADDR_WIDTH - 2);

    logic [31:0] ram [WORDS];

    soc_map_pkg::haddr_view_u av;
    logic                     accept;
    logic [3:0]               lane_en;
    logic                     wr_pend;
    logic [3:0]               wr_be;
    logic [ADDR_WIDTH-3:0]    word_q;

    assign av = addr.haddr;

    assign accept = sel && hready &&
                    (addr.htrans == ahb_pkg::htrans_nonseq ||
                     addr.htrans == ahb_pkg::htrans_seq);

    // byte lanes touched by this transfer, little endian
    always_comb begin
        case (addr.hsize)
            ahb_pkg::hsize_byte:     lane_en = 4'b0001 << av.mem.lane;
            ahb_pkg::hsize_halfword: lane_en = av.mem.lane[1] ? 4'b1100 : 4'b0011;
            default:                 lane_en = 4'b1111;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wr_pend <= 1'b0;
        end else if (hready) begin
            wr_pend <= accept && addr.hwrite;
        end
    end

    // address phase capture
    always_ff @(posedge HCLK) begin
        if (accept) begin
            word_q <= av.mem.word[ADDR_WIDTH-3:0];
            wr_be  <= lane_en;
        end
    end

    // data phase store, hwdata is valid now
    always_ff @(posedge HCLK) begin
        if (wr_pend && hready) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_be[i]) begin
                    ram[word_q][8*i +: 8] <= hwdata[8*i +: 8];
                end
            end
        end
    end

    // read from the registered index so a write just before is seen
    assign resp.hrdata    = ram[word_q];
    assign resp.hreadyout = 1'b1;
    assign resp.hresp     = ahb_pkg::hresp_okay;

endmodule

/* ahb_gpio_slave.sv */
module ahb_gpio_slave (
    input  logic               HCLK,
    input  logic               rst_n,
    input  ahb_pkg::ahb_addr_t addr,
    input  logic               sel,
    input  logic               hready,
    input  logic [31:0]        hwdata,
    input  logic [17:0]        switches,
    input  logic [4:0]         buttons,
    output logic [17:0]        red_leds,
    output logic [8:0]         green_leds,
    output ahb_pkg::ahb_resp_t resp
);

    soc_map_pkg::haddr_view_u av;
    logic        accept;
    logic        wr_pend;
    logic [5:0]  reg_q;     // byte offset of the data-phase register
    logic [17:0] sw_q;
    logic [4:0]  btn_q;

    assign av = addr.haddr;
    assign accept = sel && hready &&
                    (addr.htrans == ahb_pkg::htrans_nonseq ||
                     addr.htrans == ahb_pkg::htrans_seq);

    // input register, one sample per cycle
    always_ff @(posedge HCLK) begin
        sw_q  <= switches;
        btn_q <= buttons;
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            wr_pend    <= 1'b0;
            red_leds   <= '0;
            green_leds <= '0;
        end else if (hready) begin
            wr_pend <= accept && addr.hwrite;
            if (wr_pend) begin
                case (reg_q)  // switch and button writes fall through
                    soc_map_pkg::GPIO_OFS_RED_LEDS:   red_leds   <= hwdata[17:0];
                    soc_map_pkg::GPIO_OFS_GREEN_LEDS: green_leds <= hwdata[8:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) reg_q <= {av.periph.regno, 2'b00};
    end

    always_comb begin
        case (reg_q)
            soc_map_pkg::GPIO_OFS_RED_LEDS:   resp.hrdata = {14'd0, red_leds};
            soc_map_pkg::GPIO_OFS_GREEN_LEDS: resp.hrdata = {23'd0, green_leds};
            soc_map_pkg::GPIO_OFS_SWITCHES:   resp.hrdata = {14'd0, sw_q};
            soc_map_pkg::GPIO_OFS_BUTTONS:    resp.hrdata = {27'd0, btn_q};
            default:                          resp.hrdata = 32'd0;
        endcase
    end

    assign resp.hreadyout = 1'b1;
    assign resp.hresp     = ahb_pkg::hresp_okay;

endmodule

/* ahb_timer_slave.sv */
module ahb_timer_slave #(
    parameter int TIMER_PRESCALE = 4
) (
    input  logic               HCLK,
    input  logic               rst_n,
    input  ahb_pkg::ahb_addr_t addr,
    input  logic               sel,
    input  logic               hready,
    input  logic [31:0]        hwdata,
    output ahb_pkg::ahb_resp_t resp,
    output logic               match
);

    localparam int PW = (TIMER_PRESCALE > 1) ? $clog2(TIMER_PRESCALE) : 1;

    soc_map_pkg::haddr_view_u av;
    logic          accept;
    logic          wr_pend;
    logic [5:0]    reg_q;
    logic [PW-1:0] presc;
    logic          tick;
    logic [31:0]   count;
    logic [31:0]   compare;
    logic          hit;
    logic          clr;

    assign av = addr.haddr;
    assign accept = sel && hready &&
                    (addr.htrans == ahb_pkg::htrans_nonseq ||
                     addr.htrans == ahb_pkg::htrans_seq);

    assign tick = presc == PW'(TIMER_PRESCALE - 1);
    // flag goes up on the same edge the count reaches compare
    assign hit  = tick && (count + 32'd1 == compare) && (compare != 32'd0);
    assign clr  = wr_pend && hready && reg_q == soc_map_pkg::TIMER_OFS_STATUS && hwdata[0];

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            presc   <= '0;
            count   <= '0;
            compare <= '0;
            match   <= 1'b0;
            wr_pend <= 1'b0;
        end else begin
            presc <= tick ? '0 : presc + 1'b1;
            if (tick) count <= count + 32'd1;
            if (clr)
                match <= 1'b0;   // write-one-to-clear beats a new hit
            else if (hit)
                match <= 1'b1;
            if (hready) begin
                wr_pend <= accept && addr.hwrite;
                if (wr_pend && reg_q == soc_map_pkg::TIMER_OFS_COMPARE)
                    compare <= hwdata;
            end
        end
    end

    always_ff @(posedge HCLK) begin
        if (accept) reg_q <= {av.periph.regno, 2'b00};
    end

    always_comb begin
        case (reg_q)
            soc_map_pkg::TIMER_OFS_COUNT:   resp.hrdata = count;
            soc_map_pkg::TIMER_OFS_COMPARE: resp.hrdata = compare;
            soc_map_pkg::TIMER_OFS_STATUS:  resp.hrdata = {31'd0, match};
            default:                        resp.hrdata = 32'd0;
        endcase
    end

    assign resp.hreadyout = 1'b1;
    assign resp.hresp     = ahb_pkg::hresp_okay;

endmodule

/* ahb_default_slave.sv */
module ahb_default_slave (
    input  logic               HCLK,
    input  logic               rst_n,
    input  ahb_pkg::ahb_addr_t addr,
    input  logic               sel,
    input  logic               hready,
    output ahb_pkg::ahb_resp_t resp
);

    typedef enum logic [1:0] {
        st_idle,
        st_error_first,
        st_error_last
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   accept;

    assign accept = sel && hready &&
                    (addr.htrans == ahb_pkg::htrans_nonseq ||
                     addr.htrans == ahb_pkg::htrans_seq);

    always_comb begin
        state_nxt = state;
        case (state)
            st_idle:        if (accept) state_nxt = st_error_first;
            st_error_first: state_nxt = st_error_last;  // hready low, nothing accepted
            st_error_last:  state_nxt = accept ? st_error_first : st_idle;
            default:        state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    // two-cycle error: stall with error, then release with error
    assign resp.hreadyout = state != st_error_first;
    assign resp.hresp     = (state == st_idle) ? ahb_pkg::hresp_okay : ahb_pkg::hresp_error;
    assign resp.hrdata    = 32'd0;

endmodule

/* ahb_read_mux.sv */
module ahb_read_mux (
    input  logic                                HCLK,
    input  logic                                rst_n,
    input  logic [soc_map_pkg::NUM_REGIONS-1:0] sel,
    input  logic                                hready,
    input  ahb_pkg::ahb_resp_t                  resp_boot,
    input  ahb_pkg::ahb_resp_t                  resp_ram,
    input  ahb_pkg::ahb_resp_t                  resp_gpio,
    input  ahb_pkg::ahb_resp_t                  resp_timer,
    input  ahb_pkg::ahb_resp_t                  resp_none,
    output logic [31:0]                         hrdata,
    output logic                                hready_out,
    output ahb_pkg::hresp_e                     hresp
);

    logic [soc_map_pkg::NUM_REGIONS-1:0] sel_q;   // data-phase owner
    ahb_pkg::ahb_resp_t                  resp_arr [soc_map_pkg::NUM_REGIONS];

    assign resp_arr[soc_map_pkg::boot_ram] = resp_boot;
    assign resp_arr[soc_map_pkg::main_ram] = resp_ram;
    assign resp_arr[soc_map_pkg::gpio]     = resp_gpio;
    assign resp_arr[soc_map_pkg::timer]    = resp_timer;
    assign resp_arr[soc_map_pkg::none]     = resp_none;

    always_ff @(posedge HCLK) begin
        if (!rst_n) begin
            sel_q <= '0;
        end else if (hready) begin
            sel_q <= sel;
        end
    end

    always_comb begin
        hrdata     = 32'd0;   // nobody owns the data phase yet
        hready_out = 1'b1;
        hresp      = ahb_pkg::hresp_okay;
        for (int i = 0; i < soc_map_pkg::NUM_REGIONS; i++) begin
            if (sel_q[i]) begin
                hrdata     = resp_arr[i].hrdata;
                hready_out = resp_arr[i].hreadyout;
                hresp      = resp_arr[i].hresp;
            end
        end
    end

endmodule

/* ahb_lite_matrix.sv */
module ahb_lite_matrix #(
    parameter int BOOT_ADDR_WIDTH = 15,
    parameter int RAM_ADDR_WIDTH  = 16,
    parameter int TIMER_PRESCALE  = 4
) (
    input  logic        HCLK,
    input  logic        rst_n,
    input  logic [31:0] haddr,
    input  logic [2:0]  hburst,
    input  logic        hmastlock,
    input  logic [3:0]  hprot,
    input  logic [2:0]  hsize,
    input  logic [1:0]  htrans,
    input  logic [31:0] hwdata,
    input  logic        hwrite,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp,
    input  logic [17:0] switches,
    input  logic [4:0]  buttons,
    output logic [17:0] red_leds,
    output logic [8:0]  green_leds,
    output logic        timer_match
);

    ahb_pkg::ahb_addr_t                  addr_ph;
    logic [soc_map_pkg::NUM_REGIONS-1:0] sel;
    ahb_pkg::ahb_resp_t                  resp_boot;
    ahb_pkg::ahb_resp_t                  resp_ram;
    ahb_pkg::ahb_resp_t                  resp_gpio;
    ahb_pkg::ahb_resp_t                  resp_timer;
    ahb_pkg::ahb_resp_t                  resp_none;
    ahb_pkg::hresp_e                     hresp_mux;

    assign addr_ph.haddr     = haddr;
    assign addr_ph.htrans    = ahb_pkg::htrans_e'(htrans);
    assign addr_ph.hwrite    = hwrite;
    assign addr_ph.hsize     = ahb_pkg::hsize_e'(hsize);
    assign addr_ph.hburst    = hburst;
    assign addr_ph.hprot     = hprot;
    assign addr_ph.hmastlock = hmastlock;

    assign hresp = hresp_mux;

    ahb_decoder decoder (
        .addr (addr_ph),
        .sel  (sel)
    );

    ahb_mem_slave #(.ADDR_WIDTH(BOOT_ADDR_WIDTH)) boot_ram (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .addr   (addr_ph),
        .sel    (sel[soc_map_pkg::boot_ram]),
        .hready (hready),
        .hwdata (hwdata),
        .resp   (resp_boot)
    );

    ahb_mem_slave #(.ADDR_WIDTH(RAM_ADDR_WIDTH)) main_ram (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .addr   (addr_ph),
        .sel    (sel[soc_map_pkg::main_ram]),
        .hready (hready),
        .hwdata (hwdata),
        .resp   (resp_ram)
    );

    ahb_gpio_slave gpio (
        .HCLK       (HCLK),
        .rst_n      (rst_n),
        .addr       (addr_ph),
        .sel        (sel[soc_map_pkg::gpio]),
        .hready     (hready),
        .hwdata     (hwdata),
        .switches   (switches),
        .buttons    (buttons),
        .red_leds   (red_leds),
        .green_leds (green_leds),
        .resp       (resp_gpio)
    );

    ahb_timer_slave #(.TIMER_PRESCALE(TIMER_PRESCALE)) timer (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .addr   (addr_ph),
        .sel    (sel[soc_map_pkg::timer]),
        .hready (hready),
        .hwdata (hwdata),
        .resp   (resp_timer),
        .match  (timer_match)
    );

    ahb_default_slave default_slave (
        .HCLK   (HCLK),
        .rst_n  (rst_n),
        .addr   (addr_ph),
        .sel    (sel[soc_map_pkg::none]),
        .hready (hready),
        .resp   (resp_none)
    );

    // hready_out loops back as hready to every slave
    ahb_read_mux read_mux (
        .HCLK       (HCLK),
        .rst_n      (rst_n),
        .sel        (sel),
        .hready     (hready),
        .resp_boot  (resp_boot),
        .resp_ram   (resp_ram),
        .resp_gpio  (resp_gpio),
        .resp_timer (resp_timer),
        .resp_none  (resp_none),
        .hrdata     (hrdata),
        .hready_out (hready),
        .hresp      (hresp_mux)
    );

endmodule

/* ahb_lite_props.sv */
module ahb_lite_props (
    input logic                                HCLK,
    input logic                                rst_n,
    input logic [31:0]                         haddr,
    input logic [1:0]                          htrans,
    input logic                                hwrite,
    input logic [31:0]                         hwdata,
    input logic                                hready,
    input logic                                hresp,
    input logic [soc_map_pkg::NUM_REGIONS-1:0] sel,
    input logic [17:0]                         red_leds,
    input logic [8:0]                          green_leds,
    input logic                                timer_match
);

    int unsigned fail_count = 0;   // read by the testbench
    logic        active;

    assign active = hready && htrans[1];   // nonseq or seq taken

    // stall with error, then release with error
    a_unmapped: assert property (@(posedge HCLK) disable iff (!rst_n)
        active && sel[soc_map_pkg::none] |=> (!hready && hresp) ##1 (hready && hresp))
    else begin
        fail_count++;
        $error("unmapped access did not get the two-cycle error response");
    end

    a_mapped_okay: assert property (@(posedge HCLK) disable iff (!rst_n)
        active && !sel[soc_map_pkg::none] |=> !hresp)
    else begin
        fail_count++;
        $error("mapped access answered with an error response");
    end

    a_red_leds: assert property (@(posedge HCLK) disable iff (!rst_n)
        active && hwrite && sel[soc_map_pkg::gpio] && haddr[5:2] == 4'h0
        |=> hready ##1 (red_leds == $past(hwdata[17:0])))
    else begin
        fail_count++;
        $error("red_leds did not take the written value");
    end

    a_green_leds: assert property (@(posedge HCLK) disable iff (!rst_n)
        active && hwrite && sel[soc_map_pkg::gpio] && haddr[5:2] == 4'h1
        |=> hready ##1 (green_leds == $past(hwdata[8:0])))
    else begin
        fail_count++;
        $error("green_leds did not take the written value");
    end

    // no data phase in flight, so nothing can clear the flag
    a_match_hold: assert property (@(posedge HCLK) disable iff (!rst_n)
        timer_match && !$past(htrans[1]) |=> timer_match)
    else begin
        fail_count++;
        $error("timer_match dropped without a status write");
    end

    a_idle_ready: assert property (@(posedge HCLK) disable iff (!rst_n)
        htrans == 2'b00 && $past(htrans) == 2'b00 |-> hready)
    else begin
        fail_count++;
        $error("hready went low during idle transfers");
    end

endmodule

bind ahb_lite_matrix ahb_lite_props props (
    .HCLK        (HCLK),
    .rst_n       (rst_n),
    .haddr       (haddr),
    .htrans      (htrans),
    .hwrite      (hwrite),
    .hwdata      (hwdata),
    .hready      (hready),
    .hresp       (hresp),
    .sel         (sel),
    .red_leds    (red_leds),
    .green_leds  (green_leds),
    .timer_match (timer_match)
);

/* tb_ahb_lite_matrix.sv */
module tb_ahb_lite_matrix;

    localparam int          PRESCALE      = 4;
    localparam int          TIMEOUT       = 50;
    localparam int          MATCH_TIMEOUT = 200;
    localparam logic [31:0] BOOT_BASE     = 32'h1FC0_0000;
    localparam logic [31:0] GPIO_BASE     = 32'h1F80_0000;
    localparam logic [31:0] TIMER_BASE    = 32'h1F40_0000;

    logic        HCLK;
    logic        rst_n;
    logic [31:0] haddr;
    logic [2:0]  hburst;
    logic        hmastlock;
    logic [3:0]  hprot;
    logic [2:0]  hsize;
    logic [1:0]  htrans;
    logic [31:0] hwdata;
    logic        hwrite;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    logic [17:0] switches;
    logic [4:0]  buttons;
    logic [17:0] red_leds;
    logic [8:0]  green_leds;
    logic        timer_match;

    int          mismatches;
    int          timeouts;
    int          cycle;
    int          read_cycle;   // cycle of the last read sample
    logic [31:0] mem_model [logic [31:0]];

    ahb_lite_matrix #(.TIMER_PRESCALE(PRESCALE)) uut (.*);

    always #2 HCLK = ~HCLK;

    always @(posedge HCLK) cycle <= cycle + 1;

    // returns at a falling edge with hready high
    task automatic wait_ready();
        int n;
        n = 0;
        @(negedge HCLK);
        while (!hready && n < TIMEOUT) begin
            @(negedge HCLK);
            n++;
        end
        if (!hready) begin
            timeouts++;
            $display("timeout: hready stayed low at cycle %0d", cycle);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic bus_write(input logic [31:0] a, input logic [2:0] sz, input logic [31:0] d);
        haddr  <= a;
        hsize  <= sz;
        hwrite <= 1'b1;
        htrans <= 2'b10;
        wait_ready();
        @(posedge HCLK);
        htrans <= 2'b00;   // data phase
        hwrite <= 1'b0;
        hwdata <= d;
        wait_ready();
        @(posedge HCLK);
    endtask

    task automatic bus_read(input logic [31:0] a, output logic [31:0] d, output logic r);
        haddr  <= a;
        hsize  <= 3'b010;
        hwrite <= 1'b0;
        htrans <= 2'b10;
        wait_ready();
        @(posedge HCLK);
        htrans <= 2'b00;
        wait_ready();
        d = hrdata;
        r = hresp;
        read_cycle = cycle;
        @(posedge HCLK);
    endtask

    task automatic check_read(input logic [31:0] a, input logic [31:0] exp);
        logic [31:0] d;
        logic        r;
        bus_read(a, d, r);
        check_value($sformatf("hrdata @%h", a), exp, d);
        if (r !== 1'b0) begin
            mismatches++;
            $display("read of %h ended with an error response", a);
        end
    endtask

    // aligned transfer of 2**size bytes on little endian lanes
    function automatic logic [31:0] merge_lanes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [2:0] sz, input logic [1:0] lo);
        int nbytes;
        int first;
        nbytes = 1 << sz;
        first  = int'(lo) & ~(nbytes - 1);
        for (int i = first; i < first + nbytes; i++) begin
            old[8*i +: 8] = d[8*i +: 8];
        end
        return old;
    endfunction

    task automatic ram_write(input logic [31:0] a, input logic [2:0] sz, input logic [31:0] d);
        logic [31:0] w;
        w = {a[31:2], 2'b00};
        bus_write(a, sz, d);
        mem_model[w] = merge_lanes(mem_model.exists(w) ? mem_model[w] : 32'h0, d, sz, a[1:0]);
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] c1;
        logic [31:0] c2;
        logic        rsp;
        logic [31:0] q [$];
        logic [17:0] sw;
        logic [4:0]  bt;
        logic [17:0] red;
        logic [8:0]  green;
        int          n;
        int          span;
        int          delta;
        HCLK = 1'b0;
        rst_n = 1'b0;
        haddr = '0;
        hburst = '0;
        hmastlock = 1'b0;
        hprot = '0;
        hsize = 3'b010;
        htrans = 2'b00;
        hwdata = '0;
        hwrite = 1'b0;
        switches = '0;
        buttons = '0;
        mismatches = 0;
        timeouts = 0;
        cycle = 0;
        void'($urandom(1983));
        repeat (8) @(posedge HCLK);
        rst_n <= 1'b1;
        @(posedge HCLK);
        @(negedge HCLK);
        check_value("hready", 32'h1, hready);
        check_value("hresp", 32'h0, hresp);
        check_value("red_leds", 32'h0, red_leds);
        check_value("green_leds", 32'h0, green_leds);
        @(posedge HCLK);
        for (int i = 0; i < 6; i++) begin   // idle to random regions
            haddr <= $urandom;
            @(posedge HCLK);
        end

        for (int i = 0; i < 8; i++) begin
            a = i[0] ? (BOOT_BASE | ($urandom & 32'h7FFC)) : ($urandom & 32'hFFFC);
            q.push_back(a);
            ram_write(a, 3'b010, $urandom);
        end
        foreach (q[i]) check_read(q[i], mem_model[q[i]]);
        ram_write(q[0] | 32'h1, 3'b000, $urandom);
        ram_write(q[1] | 32'h2, 3'b001, $urandom);
        check_read(q[0], mem_model[q[0]]);
        check_read(q[1], mem_model[q[1]]);

        bus_read(32'h1F00_0010, d, rsp);
        if (rsp !== 1'b1) begin
            mismatches++;
            $display("unmapped read did not end with an error response");
        end
        bus_write(32'h3000_0000, 3'b010, $urandom);
        check_read(q[2], mem_model[q[2]]);

        d = $urandom;
        bus_write(GPIO_BASE, 3'b010, d);
        red = d[17:0];
        check_read(GPIO_BASE, {14'd0, red});
        d = $urandom;
        bus_write(GPIO_BASE + 32'h4, 3'b010, d);
        green = d[8:0];
        check_read(GPIO_BASE + 32'h4, {23'd0, green});
        sw = $urandom;
        bt = $urandom;
        switches <= sw;
        buttons  <= bt;
        repeat (3) @(posedge HCLK);
        check_read(GPIO_BASE + 32'h8, {14'd0, sw});
        check_read(GPIO_BASE + 32'hC, {27'd0, bt});
        bus_write(GPIO_BASE + 32'h8, 3'b010, $urandom);   // read-only register
        check_read(GPIO_BASE + 32'h8, {14'd0, sw});
        @(negedge HCLK);
        check_value("red_leds", {14'd0, red}, red_leds);
        check_value("green_leds", {23'd0, green}, green_leds);
        @(posedge HCLK);

        bus_read(TIMER_BASE, c1, rsp);
        bus_write(TIMER_BASE + 32'h4, 3'b010, c1 + 32'd20);
        check_read(TIMER_BASE + 32'h4, c1 + 32'd20);
        n = 0;
        @(negedge HCLK);
        while (!timer_match && n < MATCH_TIMEOUT) begin
            @(negedge HCLK);
            n++;
        end
        if (!timer_match) begin
            timeouts++;
            $display("timeout: timer_match never rose");
        end
        repeat (10) @(posedge HCLK);
        @(negedge HCLK);
        check_value("timer_match", 32'h1, timer_match);
        @(posedge HCLK);
        bus_write(TIMER_BASE + 32'h8, 3'b010, 32'h1);
        @(negedge HCLK);
        check_value("timer_match", 32'h0, timer_match);
        @(posedge HCLK);
        check_read(TIMER_BASE + 32'h8, 32'h0);

        bus_read(TIMER_BASE, c1, rsp);
        span = read_cycle;
        repeat (40) @(posedge HCLK);
        bus_read(TIMER_BASE, c2, rsp);
        span = read_cycle - span;
        delta = int'(c2 - c1);
        if (delta < span / PRESCALE - 1 || delta > span / PRESCALE + 1) begin
            mismatches++;
            $display("timer count advanced by %0d over %0d cycles", delta, span);
        end

        repeat (4) @(posedge HCLK);
        $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatches, timeouts, uut.props.fail_count);
        if (mismatches == 0 && timeouts == 0 && uut.props.fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* ahb_lite_soc.f */
ahb_pkg.sv
soc_map_pkg.sv
ahb_decoder.sv
ahb_mem_slave.sv
ahb_gpio_slave.sv
ahb_timer_slave.sv
ahb_default_slave.sv
ahb_read_mux.sv
ahb_lite_matrix.sv
ahb_lite_props.sv
tb_ahb_lite_matrix.sv
